//--- rtl/mem_pkg.sv
package mem_pkg;

    // Bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    // Physical address split into region select and in-region offset
    localparam int SELECT_W = 8;
    localparam int OFFSET_W = ADDR_W - SELECT_W;

    // Address map, one select value per device region
    localparam logic [SELECT_W-1:0] ROM_SELECT = 8'h00;
    localparam logic [SELECT_W-1:0] RAM_SELECT = 8'h01;

    // Implemented depths; higher offset bits alias onto these words
    localparam int ROM_WORDS = 128;
    localparam int ROM_AW    = 7;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;

    // Boot image, one 32-bit hex word per line
    localparam string ROM_INIT_FILE = "rtl/boot_rom_init.hex";

    // Decoder view of a physical address
    typedef struct packed {
        logic [SELECT_W-1:0] select;
        logic [OFFSET_W-1:0] offset;
    } mem_addr_split_t;

    // Requesters build the raw word, the decoder reads the split view
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        mem_addr_split_t   split;
    } mem_addr_u;

    // One word access from an MMU
    typedef struct packed {
        logic              write;
        mem_addr_u         addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Completion returned with ack
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    // Region hit by the current access
    typedef enum logic [1:0] {
        REGION_ROM,
        REGION_RAM,
        REGION_NONE
    } mem_region_e;

endpackage

//--- rtl/addr_decode.sv
`timescale 1ns/1ps

module addr_decode
    import mem_pkg::*;
(
    input  mem_addr_u   addr,
    input  logic        write,
    output mem_region_e region,
    output logic        fault
);

    // Only the select field matters here, the offset goes to the device
    always_comb begin
        case (addr.split.select)
            ROM_SELECT: region = REGION_ROM;
            RAM_SELECT: region = REGION_RAM;
            default:    region = REGION_NONE;
        endcase
    end

    // Unmapped space, or an attempt to write the boot ROM
    always_comb begin
        fault = 1'b0;
        if (region == REGION_NONE) begin
            fault = 1'b1;
        end else if (region == REGION_ROM && write) begin
            fault = 1'b1;
        end
    end

endmodule

//--- rtl/boot_rom.sv
`timescale 1ns/1ps

module boot_rom
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rd,
    input  logic [ROM_AW-1:0] index,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [ROM_WORDS];

    // Boot image is fixed at elaboration
    initial begin
        $readmemh(ROM_INIT_FILE, mem);
    end

    // Output holds its last word between reads
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[index];
        end
    end

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rd,
    input  logic              we,
    input  logic [RAM_AW-1:0] index,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [RAM_WORDS];

    // Single port, full-word write or registered read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        if (rd) begin
            rdata <= mem[index];
        end
    end

    // The controller serves one access at a time, so the port is never shared
    a_single_op: assert property (@(posedge clk) !(rd && we))
        else $error("data_ram read and write strobes overlap");

endmodule

//--- rtl/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    input  logic              immu_req,
    input  mem_req_t          immu_cmd,
    output logic              immu_ack,
    output mem_rsp_t          immu_rsp,

    input  logic              dmmu_req,
    input  mem_req_t          dmmu_cmd,
    output logic              dmmu_ack,
    output mem_rsp_t          dmmu_rsp,

    output mem_addr_u         cur_addr,
    output logic              cur_write,
    input  mem_region_e       region,
    input  logic              fault,

    output logic              rom_rd,
    output logic [ROM_AW-1:0] rom_index,
    input  logic [DATA_W-1:0] rom_rdata,

    output logic              ram_rd,
    output logic              ram_we,
    output logic [RAM_AW-1:0] ram_index,
    output logic [DATA_W-1:0] ram_wdata,
    input  logic [DATA_W-1:0] ram_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND,
        ST_RELEASE
    } state_e;

    state_e   state;
    logic     grant_dmmu;
    logic     take;
    logic     granted_req;
    logic     access_ok;
    mem_req_t req_q;
    mem_rsp_t rsp_q;
    mem_rsp_t rsp_d;

    // Fixed priority with the dmmu first
    assign take        = (state == ST_IDLE) && (dmmu_req || immu_req);
    assign granted_req = grant_dmmu ? dmmu_req : immu_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            grant_dmmu <= 1'b0;
            immu_ack   <= 1'b0;
            dmmu_ack   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        grant_dmmu <= dmmu_req;
                        state      <= ST_ACCESS;
                    end
                end
                ST_ACCESS:  state <= ST_RESPOND;
                ST_RESPOND: begin
                    dmmu_ack <= grant_dmmu;
                    immu_ack <= !grant_dmmu;
                    state    <= ST_RELEASE;
                end
                default: begin
                    // Hold ack until the winner lets go of req
                    if (!granted_req) begin
                        dmmu_ack <= 1'b0;
                        immu_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= dmmu_req ? dmmu_cmd : immu_cmd;
        end
        if (state == ST_RESPOND) begin
            rsp_q <= rsp_d;
        end
    end

    assign cur_addr  = req_q.addr;
    assign cur_write = req_q.write;

    // One strobe cycle in ACCESS unless the access faults
    assign access_ok = (state == ST_ACCESS) && !fault;
    assign rom_rd    = access_ok && (region == REGION_ROM);
    assign ram_rd    = access_ok && (region == REGION_RAM) && !req_q.write;
    assign ram_we    = access_ok && (region == REGION_RAM) && req_q.write;
    assign rom_index = req_q.addr.split.offset[ROM_AW+1:2];
    assign ram_index = req_q.addr.split.offset[RAM_AW+1:2];
    assign ram_wdata = req_q.wdata;

    // Writes and faults complete with zero data
    always_comb begin
        rsp_d.err   = fault;
        rsp_d.rdata = '0;
        if (!fault && !req_q.write) begin
            rsp_d.rdata = (region == REGION_ROM) ? rom_rdata : ram_rdata;
        end
    end

    // Only the acked port looks at its response
    assign immu_rsp = rsp_q;
    assign dmmu_rsp = rsp_q;

    a_ack_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(immu_ack && dmmu_ack));

    // Ack is up on the third edge after the grant
    a_ack_latency: assert property (@(posedge clk) disable iff (!arst_n)
        take |-> ##3 (immu_ack || dmmu_ack));

    // Ack stays up while its requester still holds req
    a_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ((dmmu_ack && dmmu_req) || (immu_ack && immu_req)) |=> (dmmu_ack || immu_ack));

endmodule

//--- rtl/mem_system.sv
`timescale 1ns/1ps

module mem_system
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    input  logic     immu_req,
    input  mem_req_t immu_cmd,
    output logic     immu_ack,
    output mem_rsp_t immu_rsp,

    input  logic     dmmu_req,
    input  mem_req_t dmmu_cmd,
    output logic     dmmu_ack,
    output mem_rsp_t dmmu_rsp
);

    mem_addr_u         cur_addr;
    logic              cur_write;
    mem_region_e       region;
    logic              fault;
    logic              rom_rd;
    logic [ROM_AW-1:0] rom_index;
    logic [DATA_W-1:0] rom_rdata;
    logic              ram_rd;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_index;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_rdata;

    mem_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .immu_req  (immu_req),
        .immu_cmd  (immu_cmd),
        .immu_ack  (immu_ack),
        .immu_rsp  (immu_rsp),
        .dmmu_req  (dmmu_req),
        .dmmu_cmd  (dmmu_cmd),
        .dmmu_ack  (dmmu_ack),
        .dmmu_rsp  (dmmu_rsp),
        .cur_addr  (cur_addr),
        .cur_write (cur_write),
        .region    (region),
        .fault     (fault),
        .rom_rd    (rom_rd),
        .rom_index (rom_index),
        .rom_rdata (rom_rdata),
        .ram_rd    (ram_rd),
        .ram_we    (ram_we),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    // Decodes the latched request, not the live requester inputs
    addr_decode u_decode (
        .addr   (cur_addr),
        .write  (cur_write),
        .region (region),
        .fault  (fault)
    );

    boot_rom u_rom (
        .clk   (clk),
        .rd    (rom_rd),
        .index (rom_index),
        .rdata (rom_rdata)
    );

    data_ram u_ram (
        .clk   (clk),
        .rd    (ram_rd),
        .we    (ram_we),
        .index (ram_index),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release away from the active edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- verification/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system
    import mem_pkg::*;
();

    localparam int RAM_FILL = 32;
    localparam int NUM_RAND = 100;
    // Aliased reads, the fault group and the same-edge pair add 20 accesses
    localparam int PLANNED  = ROM_WORDS + 2 * RAM_FILL + 20 + 2 * NUM_RAND;

    typedef struct packed {
        logic     is_dmmu;
        mem_req_t cmd;
        mem_rsp_t rsp;
    } done_t;

    logic     clk;
    logic     arst_n;
    logic     immu_req;
    logic     dmmu_req;
    mem_req_t immu_cmd;
    mem_req_t dmmu_cmd;
    logic     immu_ack;
    logic     dmmu_ack;
    mem_rsp_t immu_rsp;
    mem_rsp_t dmmu_rsp;

    logic [DATA_W-1:0] model_rom [ROM_WORDS];
    logic [DATA_W-1:0] model_ram [RAM_WORDS];
    done_t             done_q[$];
    int                grant_log[$];
    int                issued;
    int                checked;
    logic              i_ack_q;
    logic              i_req_q;
    logic              d_ack_q;
    logic              d_req_q;

    clk_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mem_system uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .immu_req (immu_req),
        .immu_cmd (immu_cmd),
        .immu_ack (immu_ack),
        .immu_rsp (immu_rsp),
        .dmmu_req (dmmu_req),
        .dmmu_cmd (dmmu_cmd),
        .dmmu_ack (dmmu_ack),
        .dmmu_rsp (dmmu_rsp)
    );

    task automatic fail_now(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rsp(input mem_rsp_t exp, input mem_rsp_t got, input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s expected rdata %h err %b, got rdata %h err %b",
                what, exp.rdata, exp.err, got.rdata, got.err));
        end
    endtask

    task automatic check_order(input int exp[$]);
        if (grant_log != exp) begin
            fail_now($sformatf("grant order %p, expected %p", grant_log, exp));
        end
    endtask

    function automatic mem_req_t make_req(input logic write, input logic [7:0] sel,
                                          input logic [23:0] off, input logic [31:0] wdata);
        mem_req_t r;
        r.write    = write;
        r.addr.raw = {sel, off};
        r.wdata    = wdata;
        return r;
    endfunction

    // Expected completion from the address map; successful writes update the model RAM
    function automatic mem_rsp_t ref_access(input mem_req_t cmd);
        mem_rsp_t   rsp;
        logic [7:0] sel;
        int         word;
        rsp  = '0;
        sel  = cmd.addr.raw[31:24];
        word = int'(cmd.addr.raw[23:0]) / 4;
        if (sel == 8'h00) begin
            if (cmd.write) rsp.err = 1'b1;
            else rsp.rdata = model_rom[word % ROM_WORDS];
        end else if (sel == 8'h01) begin
            if (cmd.write) model_ram[word % RAM_WORDS] = cmd.wdata;
            else rsp.rdata = model_ram[word % RAM_WORDS];
        end else begin
            rsp.err = 1'b1;
        end
        return rsp;
    endfunction

    // Timed requests expect ack seen on the third falling edge after req
    task automatic drive_immu(input mem_req_t cmd, input bit timed);
        int    waited;
        int    hold;
        done_t e;
        @(negedge clk);
        immu_cmd = cmd;
        immu_req = 1'b1;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!immu_ack);
        if (timed && waited != 3) fail_now($sformatf("immu ack after %0d cycles", waited));
        e = '{1'b0, cmd, immu_rsp};
        done_q.push_back(e);
        issued++;
        hold = int'($urandom_range(3, 0));
        repeat (hold) @(negedge clk);
        immu_req = 1'b0;
        while (immu_ack) @(negedge clk);
    endtask

    task automatic drive_dmmu(input mem_req_t cmd, input bit timed);
        int    waited;
        int    hold;
        done_t e;
        @(negedge clk);
        dmmu_cmd = cmd;
        dmmu_req = 1'b1;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!dmmu_ack);
        if (timed && waited != 3) fail_now($sformatf("dmmu ack after %0d cycles", waited));
        e = '{1'b1, cmd, dmmu_rsp};
        done_q.push_back(e);
        issued++;
        hold = int'($urandom_range(3, 0));
        repeat (hold) @(negedge clk);
        dmmu_req = 1'b0;
        while (dmmu_ack) @(negedge clk);
    endtask

    // Completions arrive in grant order, so the model sees accesses in that order
    initial begin : compare
        done_t    e;
        mem_rsp_t exp;
        forever begin
            wait (done_q.size() > 0);
            e   = done_q.pop_front();
            exp = ref_access(e.cmd);
            check_rsp(exp, e.rsp, $sformatf("%s addr %h", e.is_dmmu ? "dmmu" : "immu",
                e.cmd.addr.raw));
            checked++;
        end
    end

    // Reads the values from before this edge so ack is from the last edge and req from the last fall
    always @(posedge clk) begin
        if (arst_n) begin
            if (immu_ack && dmmu_ack) fail_now("immu and dmmu ack are high together");
            if (immu_ack && !i_ack_q) begin
                if (!i_req_q) fail_now("immu ack rose without req");
                grant_log.push_back(0);
            end
            if (!immu_ack && i_ack_q && i_req_q) fail_now("immu ack dropped while req high");
            if (dmmu_ack && !d_ack_q) begin
                if (!d_req_q) fail_now("dmmu ack rose without req");
                grant_log.push_back(1);
            end
            if (!dmmu_ack && d_ack_q && d_req_q) fail_now("dmmu ack dropped while req high");
        end
        i_ack_q = immu_ack;
        i_req_q = immu_req;
        d_ack_q = dmmu_ack;
        d_req_q = dmmu_req;
    end

    initial begin : watchdog
        #(PLANNED * 20 * 20);
        $display("Timeout: the accesses did not all complete in the expected time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int         exp_order[$];
        logic [7:0] sel;
        void'($urandom(32'hc51d77eb));
        immu_req = 1'b0;
        dmmu_req = 1'b0;
        immu_cmd = '0;
        dmmu_cmd = '0;
        issued   = 0;
        checked  = 0;
        i_ack_q  = 1'b0;
        i_req_q  = 1'b0;
        d_ack_q  = 1'b0;
        d_req_q  = 1'b0;
        $readmemh(ROM_INIT_FILE, model_rom);
        @(posedge arst_n);
        @(negedge clk);
        if (immu_ack !== 1'b0 || dmmu_ack !== 1'b0) fail_now("ack is high after reset");

        // Whole boot image through the immu
        for (int i = 0; i < ROM_WORDS; i++) begin
            drive_immu(make_req(1'b0, 8'h00, 24'(i * 4), '0), 1'b1);
        end

        // RAM fill, readback, then aliased readback
        for (int i = 0; i < RAM_FILL; i++) begin
            drive_dmmu(make_req(1'b1, 8'h01, 24'(i * 4), $urandom), 1'b1);
        end
        for (int i = 0; i < RAM_FILL; i++) begin
            drive_dmmu(make_req(1'b0, 8'h01, 24'(i * 4), '0), 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            drive_dmmu(make_req(1'b0, 8'h01, 24'((i + RAM_WORDS * (i + 1)) * 4), '0), 1'b1);
        end

        // Faulting accesses, then RAM must be untouched
        for (int i = 0; i < 4; i++) begin
            sel = 8'(2 + i * 60);
            drive_dmmu(make_req(1'(i), sel, 24'(i * 4), 32'hdead_beef), 1'b1);
        end
        drive_dmmu(make_req(1'b1, 8'h00, 24'h0, 32'h1234_5678), 1'b1);
        drive_immu(make_req(1'b1, 8'h00, 24'h8, 32'h8765_4321), 1'b1);
        for (int i = 0; i < 4; i++) begin
            drive_immu(make_req(1'b0, 8'h01, 24'(i * 4), '0), 1'b1);
        end

        // Same-edge requests, dmmu wins
        wait (checked == issued);
        grant_log.delete();
        fork
            drive_immu(make_req(1'b0, 8'h00, 24'h10, '0), 1'b0);
            drive_dmmu(make_req(1'b0, 8'h01, 24'h10, '0), 1'b0);
        join
        exp_order = '{1, 0};
        check_order(exp_order);

        // Mixed traffic; RAM offsets stay on written words but alias freely
        fork
            for (int i = 0; i < NUM_RAND; i++) begin
                drive_immu(make_req(1'b0, 8'($urandom_range(1, 0)),
                    {12'($urandom), 5'b0, 5'($urandom), 2'($urandom)}, '0), 1'b0);
            end
            for (int i = 0; i < NUM_RAND; i++) begin
                sel = ($urandom_range(3, 0) == 3) ? 8'($urandom_range(255, 2))
                                                  : 8'($urandom_range(1, 0));
                drive_dmmu(make_req(1'($urandom), sel,
                    {12'($urandom), 5'b0, 5'($urandom), 2'($urandom)}, $urandom), 1'b0);
            end
        join

        wait (checked == issued);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- build.f
rtl/mem_pkg.sv
rtl/addr_decode.sv
rtl/boot_rom.sv
rtl/data_ram.sv
rtl/mem_ctrl.sv
rtl/mem_system.sv
verification/clk_gen.sv
verification/tb_mem_system.sv

//--- Makefile
# Verilator build of the memory interconnect testbench
# Override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST)) rtl/boot_rom_init.hex
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Runs from the project root so the ROM image path resolves
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/boot_rom_init.hex
// One 32-bit boot word per line, word index 0 first
C0DE0000
C0DE0001
C0DE0002
C0DE0003
C0DE0004
C0DE0005
C0DE0006
C0DE0007
C0DE0008
C0DE0009
C0DE000A
C0DE000B
C0DE000C
C0DE000D
C0DE000E
C0DE000F
C0DE0010
C0DE0011
C0DE0012
C0DE0013
C0DE0014
C0DE0015
C0DE0016
C0DE0017
C0DE0018
C0DE0019
C0DE001A
C0DE001B
C0DE001C
C0DE001D
C0DE001E
C0DE001F
C0DE0020
C0DE0021
C0DE0022
C0DE0023
C0DE0024
C0DE0025
C0DE0026
C0DE0027
C0DE0028
C0DE0029
C0DE002A
C0DE002B
C0DE002C
C0DE002D
C0DE002E
C0DE002F
C0DE0030
C0DE0031
C0DE0032
C0DE0033
C0DE0034
C0DE0035
C0DE0036
C0DE0037
C0DE0038
C0DE0039
C0DE003A
C0DE003B
C0DE003C
C0DE003D
C0DE003E
C0DE003F
C0DE0040
C0DE0041
C0DE0042
C0DE0043
C0DE0044
C0DE0045
C0DE0046
C0DE0047
C0DE0048
C0DE0049
C0DE004A
C0DE004B
C0DE004C
C0DE004D
C0DE004E
C0DE004F
C0DE0050
C0DE0051
C0DE0052
C0DE0053
C0DE0054
C0DE0055
C0DE0056
C0DE0057
C0DE0058
C0DE0059
C0DE005A
C0DE005B
C0DE005C
C0DE005D
C0DE005E
C0DE005F
C0DE0060
C0DE0061
C0DE0062
C0DE0063
C0DE0064
C0DE0065
C0DE0066
C0DE0067
C0DE0068
C0DE0069
C0DE006A
C0DE006B
C0DE006C
C0DE006D
C0DE006E
C0DE006F
C0DE0070
C0DE0071
C0DE0072
C0DE0073
C0DE0074
C0DE0075
C0DE0076
C0DE0077
C0DE0078
C0DE0079
C0DE007A
C0DE007B
C0DE007C
C0DE007D
C0DE007E
C0DE007F
